//--- div_defines.svh
`ifndef DIV_DEFINES_SVH
`define DIV_DEFINES_SVH

// Operand and result width
`define DIV_WORD_W 32

// Destination register tag width
`define DIV_TAG_W 5

// Pipeline depth, must divide DIV_WORD_W
`define DIV_STAGES 8

// Result FIFO entries, also the issuer credits after reset
`define DIV_FIFO_DEPTH 4

// Downstream credits held after reset
`define DIV_RES_CREDITS 2

`endif

//--- div_pkg.sv
`default_nettype none

`include "div_defines.svh"

package div_pkg;

  typedef logic [`DIV_WORD_W-1:0] div_word_t;
  typedef logic [`DIV_TAG_W-1:0]  div_tag_t;

  // RISC-V funct3 codes of the M extension divides
  typedef enum logic [2:0] {
    DIV_OP_DIV  = 3'd4,
    DIV_OP_DIVU = 3'd5,
    DIV_OP_REM  = 3'd6,
    DIV_OP_REMU = 3'd7
  } div_op_e;

  // Side-band that rides along with each operation
  typedef struct packed {
    div_tag_t tag;
    logic     sel_rem;
    logic     neg_quo;
    logic     neg_rem;
  } div_ctrl_t;

endpackage

`default_nettype wire

//--- div_operand_prep.sv
`timescale 1ns/100ps
`default_nettype none

`include "div_defines.svh"

module div_operand_prep (
  input  wire logic              op_valid_i,
  input  wire div_pkg::div_op_e  op_code_i,
  input  wire div_pkg::div_word_t op_a_i,
  input  wire div_pkg::div_word_t op_b_i,
  input  wire div_pkg::div_tag_t op_tag_i,
  output logic                   valid_o,
  output div_pkg::div_word_t     mag_a_o,
  output div_pkg::div_word_t     mag_b_o,
  output div_pkg::div_ctrl_t     ctrl_o,
  output logic                   special_o,
  output div_pkg::div_word_t     special_q_o,
  output div_pkg::div_word_t     special_r_o
);

  logic is_signed;
  logic sign_a;
  logic sign_b;
  logic div_zero;
  logic overflow;

  assign is_signed = (op_code_i == div_pkg::DIV_OP_DIV) || (op_code_i == div_pkg::DIV_OP_REM);
  assign sign_a    = is_signed && op_a_i[`DIV_WORD_W-1];
  assign sign_b    = is_signed && op_b_i[`DIV_WORD_W-1];

  // Unsigned core works on magnitudes
  assign mag_a_o = sign_a ? (~op_a_i + 1'b1) : op_a_i;
  assign mag_b_o = sign_b ? (~op_b_i + 1'b1) : op_b_i;

  assign ctrl_o.tag     = op_tag_i;
  assign ctrl_o.sel_rem = (op_code_i == div_pkg::DIV_OP_REM) || (op_code_i == div_pkg::DIV_OP_REMU);
  assign ctrl_o.neg_quo = sign_a ^ sign_b;
  assign ctrl_o.neg_rem = sign_a;

  // Most negative dividend over minus one
  assign div_zero = (op_b_i == '0);
  assign overflow = is_signed && (op_a_i == {1'b1, {(`DIV_WORD_W-1){1'b0}}}) && (op_b_i == '1);

  assign valid_o     = op_valid_i;
  assign special_o   = div_zero || overflow;
  assign special_q_o = div_zero ? '1 : op_a_i;
  assign special_r_o = div_zero ? op_a_i : '0;

endmodule

`default_nettype wire

//--- div_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "div_defines.svh"

module div_stage #(
  parameter int BITS_PER_STAGE = `DIV_WORD_W / `DIV_STAGES
) (
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire logic               valid_i,
  input  wire div_pkg::div_word_t rem_i,
  input  wire div_pkg::div_word_t quo_i,
  input  wire div_pkg::div_word_t dividend_i,
  input  wire div_pkg::div_word_t divisor_i,
  input  wire div_pkg::div_ctrl_t ctrl_i,
  input  wire logic               special_i,
  input  wire div_pkg::div_word_t special_q_i,
  input  wire div_pkg::div_word_t special_r_i,
  output logic                    valid_o,
  output div_pkg::div_word_t      rem_o,
  output div_pkg::div_word_t      quo_o,
  output div_pkg::div_word_t      dividend_o,
  output div_pkg::div_word_t      divisor_o,
  output div_pkg::div_ctrl_t      ctrl_o,
  output logic                    special_o,
  output div_pkg::div_word_t      special_q_o,
  output div_pkg::div_word_t      special_r_o
);

  localparam int W = `DIV_WORD_W;

  div_pkg::div_word_t rem_n;
  div_pkg::div_word_t quo_n;
  div_pkg::div_word_t dvd_n;
  logic [W:0]         shifted;
  logic [W:0]         diff;

  // Restoring shift-subtract, one quotient bit per step
  always_comb begin
    rem_n   = rem_i;
    quo_n   = quo_i;
    dvd_n   = dividend_i;
    shifted = '0;
    diff    = '0;
    for (int i = 0; i < BITS_PER_STAGE; i++) begin
      shifted = {rem_n, dvd_n[W-1]};
      dvd_n   = {dvd_n[W-2:0], 1'b0};
      diff    = shifted - {1'b0, divisor_i};
      if (!diff[W]) begin
        rem_n = diff[W-1:0];
        quo_n = {quo_n[W-2:0], 1'b1};
      end else begin
        rem_n = shifted[W-1:0];
        quo_n = {quo_n[W-2:0], 1'b0};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i) begin
      rem_o       <= rem_n;
      quo_o       <= quo_n;
      dividend_o  <= dvd_n;
      divisor_o   <= divisor_i;
      ctrl_o      <= ctrl_i;
      special_o   <= special_i;
      special_q_o <= special_q_i;
      special_r_o <= special_r_i;
    end
  end

  // Zero divisors must have been flagged as special by the prep logic
  a_divisor_nonzero: assert property (@(posedge clk) disable iff (rst)
    valid_o && !special_o |-> divisor_o != '0);

endmodule

`default_nettype wire

//--- div_result_fixup.sv
`timescale 1ns/100ps
`default_nettype none

module div_result_fixup (
  input  wire logic               valid_i,
  input  wire div_pkg::div_word_t quo_i,
  input  wire div_pkg::div_word_t rem_i,
  input  wire div_pkg::div_ctrl_t ctrl_i,
  input  wire logic               special_i,
  input  wire div_pkg::div_word_t special_q_i,
  input  wire div_pkg::div_word_t special_r_i,
  output logic                    push_o,
  output div_pkg::div_word_t      data_o,
  output div_pkg::div_tag_t       tag_o
);

  div_pkg::div_word_t quo_signed;
  div_pkg::div_word_t rem_signed;
  div_pkg::div_word_t quo_final;
  div_pkg::div_word_t rem_final;

  // Restore signs lost in the unsigned core
  assign quo_signed = ctrl_i.neg_quo ? (~quo_i + 1'b1) : quo_i;
  assign rem_signed = ctrl_i.neg_rem ? (~rem_i + 1'b1) : rem_i;

  // Divide by zero and overflow override the core
  assign quo_final = special_i ? special_q_i : quo_signed;
  assign rem_final = special_i ? special_r_i : rem_signed;

  assign push_o = valid_i;
  assign data_o = ctrl_i.sel_rem ? rem_final : quo_final;
  assign tag_o  = ctrl_i.tag;

endmodule

`default_nettype wire

//--- div_result_fifo.sv
`timescale 1ns/100ps
`default_nettype none

`include "div_defines.svh"

module div_result_fifo (
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire logic               push_i,
  input  wire div_pkg::div_word_t push_data_i,
  input  wire div_pkg::div_tag_t  push_tag_i,
  input  wire logic               res_credit_i,
  output logic                    res_valid_o,
  output div_pkg::div_word_t      res_data_o,
  output div_pkg::div_tag_t       res_tag_o,
  output logic                    op_credit_o
);

  localparam int DEPTH       = `DIV_FIFO_DEPTH;
  localparam int RES_CREDITS = `DIV_RES_CREDITS;
  localparam int PTR_W       = $clog2(DEPTH);
  localparam int CNT_W       = $clog2(DEPTH + 1);
  localparam int CRD_W       = $clog2(RES_CREDITS + 1);

  div_pkg::div_word_t mem_data [DEPTH];
  div_pkg::div_tag_t  mem_tag  [DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  logic [CRD_W-1:0]   credit;
  logic               full;
  logic               pop;

  assign full = (count == CNT_W'(DEPTH));
  assign pop  = (count != '0) && (credit != '0);

  always_ff @(posedge clk) begin
    if (push_i) begin
      mem_data[wr_ptr] <= push_data_i;
      mem_tag[wr_ptr]  <= push_tag_i;
    end
    if (pop) begin
      res_data_o <= mem_data[rd_ptr];
      res_tag_o  <= mem_tag[rd_ptr];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count       <= '0;
      credit      <= CRD_W'(RES_CREDITS);
      res_valid_o <= 1'b0;
      op_credit_o <= 1'b0;
    end else begin
      if (push_i) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push_i, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // Emitting spends a credit, a returned pulse adds one
      case ({res_credit_i, pop})
        2'b10:   credit <= credit + 1'b1;
        2'b01:   credit <= credit - 1'b1;
        default: credit <= credit;
      endcase
      res_valid_o <= pop;
      op_credit_o <= pop;
    end
  end

  // Issuer credits reserve a slot for every operation in flight
  a_no_push_full: assert property (@(posedge clk) disable iff (rst) push_i |-> !full);

  // Consumer must not return more credits than it was given
  a_credit_bound: assert property (@(posedge clk) disable iff (rst)
    credit <= CRD_W'(RES_CREDITS));

endmodule

`default_nettype wire

//--- div_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "div_defines.svh"

module div_unit (
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire logic               op_valid_i,
  input  wire div_pkg::div_op_e   op_code_i,
  input  wire div_pkg::div_word_t op_a_i,
  input  wire div_pkg::div_word_t op_b_i,
  input  wire div_pkg::div_tag_t  op_tag_i,
  output logic                    op_credit_o,
  output logic                    res_valid_o,
  output div_pkg::div_word_t      res_data_o,
  output div_pkg::div_tag_t       res_tag_o,
  input  wire logic               res_credit_i
);

  // Index i feeds stage i, the last index feeds fixup
  logic               stg_valid [0:`DIV_STAGES];
  div_pkg::div_word_t stg_rem   [0:`DIV_STAGES];
  div_pkg::div_word_t stg_quo   [0:`DIV_STAGES];
  div_pkg::div_word_t stg_dvd   [0:`DIV_STAGES];
  div_pkg::div_word_t stg_dvs   [0:`DIV_STAGES];
  div_pkg::div_ctrl_t stg_ctrl  [0:`DIV_STAGES];
  logic               stg_spc   [0:`DIV_STAGES];
  div_pkg::div_word_t stg_spc_q [0:`DIV_STAGES];
  div_pkg::div_word_t stg_spc_r [0:`DIV_STAGES];

  logic               push;
  div_pkg::div_word_t push_data;
  div_pkg::div_tag_t  push_tag;

  assign stg_rem[0] = '0;
  assign stg_quo[0] = '0;

  div_operand_prep u_prep (
    .op_valid_i  (op_valid_i),
    .op_code_i   (op_code_i),
    .op_a_i      (op_a_i),
    .op_b_i      (op_b_i),
    .op_tag_i    (op_tag_i),
    .valid_o     (stg_valid[0]),
    .mag_a_o     (stg_dvd[0]),
    .mag_b_o     (stg_dvs[0]),
    .ctrl_o      (stg_ctrl[0]),
    .special_o   (stg_spc[0]),
    .special_q_o (stg_spc_q[0]),
    .special_r_o (stg_spc_r[0])
  );

  for (genvar i = 0; i < `DIV_STAGES; i++) begin : g_stage
    div_stage #(
      .BITS_PER_STAGE(`DIV_WORD_W / `DIV_STAGES)
    ) u_stage (
      .clk         (clk),
      .rst         (rst),
      .valid_i     (stg_valid[i]),
      .rem_i       (stg_rem[i]),
      .quo_i       (stg_quo[i]),
      .dividend_i  (stg_dvd[i]),
      .divisor_i   (stg_dvs[i]),
      .ctrl_i      (stg_ctrl[i]),
      .special_i   (stg_spc[i]),
      .special_q_i (stg_spc_q[i]),
      .special_r_i (stg_spc_r[i]),
      .valid_o     (stg_valid[i+1]),
      .rem_o       (stg_rem[i+1]),
      .quo_o       (stg_quo[i+1]),
      .dividend_o  (stg_dvd[i+1]),
      .divisor_o   (stg_dvs[i+1]),
      .ctrl_o      (stg_ctrl[i+1]),
      .special_o   (stg_spc[i+1]),
      .special_q_o (stg_spc_q[i+1]),
      .special_r_o (stg_spc_r[i+1])
    );
  end

  div_result_fixup u_fixup (
    .valid_i     (stg_valid[`DIV_STAGES]),
    .quo_i       (stg_quo[`DIV_STAGES]),
    .rem_i       (stg_rem[`DIV_STAGES]),
    .ctrl_i      (stg_ctrl[`DIV_STAGES]),
    .special_i   (stg_spc[`DIV_STAGES]),
    .special_q_i (stg_spc_q[`DIV_STAGES]),
    .special_r_i (stg_spc_r[`DIV_STAGES]),
    .push_o      (push),
    .data_o      (push_data),
    .tag_o       (push_tag)
  );

  div_result_fifo u_fifo (
    .clk          (clk),
    .rst          (rst),
    .push_i       (push),
    .push_data_i  (push_data),
    .push_tag_i   (push_tag),
    .res_credit_i (res_credit_i),
    .res_valid_o  (res_valid_o),
    .res_data_o   (res_data_o),
    .res_tag_o    (res_tag_o),
    .op_credit_o  (op_credit_o)
  );

endmodule

`default_nettype wire

//--- tb_div_checker.sv
`timescale 1ns/100ps
`default_nettype none

`include "div_defines.svh"

module tb_div_checker (
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire logic               op_valid_i,
  input  wire div_pkg::div_op_e   op_code_i,
  input  wire div_pkg::div_word_t op_a_i,
  input  wire div_pkg::div_word_t op_b_i,
  input  wire div_pkg::div_tag_t  op_tag_i,
  input  wire logic               op_credit_i,
  input  wire logic               res_valid_i,
  input  wire div_pkg::div_word_t res_data_i,
  input  wire div_pkg::div_tag_t  res_tag_i,
  input  wire logic               res_credit_i,
  input  wire logic               totals_i,
  output int                      error_count_o,
  output int                      result_count_o,
  output int                      totals_done_o
);

  div_pkg::div_word_t exp_data_q [$];
  div_pkg::div_tag_t  exp_tag_q  [$];
  div_pkg::div_word_t exp_data;
  div_pkg::div_tag_t  exp_tag;
  int                 errors      = 0;
  int                 results     = 0;
  int                 op_credits  = 0;
  int                 res_credits = 0;
  int                 totals_done = 0;
  bit                 issued_any  = 1'b0;

  // RISC-V rules, division truncates and the remainder keeps the dividend sign
  function automatic div_pkg::div_word_t model_result(input div_pkg::div_op_e code,
                                                      input div_pkg::div_word_t a,
                                                      input div_pkg::div_word_t b);
    logic signed [`DIV_WORD_W-1:0] sa;
    logic signed [`DIV_WORD_W-1:0] sb;
    div_pkg::div_word_t            quo;
    div_pkg::div_word_t            rem;
    logic                          is_signed;
    sa = a;
    sb = b;
    is_signed = (code == div_pkg::DIV_OP_DIV) || (code == div_pkg::DIV_OP_REM);
    if (b == '0) begin
      quo = '1;
      rem = a;
    end else if (is_signed && a == {1'b1, {(`DIV_WORD_W-1){1'b0}}} && sb == -1) begin
      quo = a;
      rem = '0;
    end else if (is_signed) begin
      quo = sa / sb;
      rem = sa % sb;
    end else begin
      quo = a / b;
      rem = a % b;
    end
    if (code == div_pkg::DIV_OP_REM || code == div_pkg::DIV_OP_REMU) begin
      return rem;
    end
    return quo;
  endfunction

  always @(posedge clk) begin
    if (!rst) begin
      if (op_credit_i) op_credits++;
      if (res_credit_i) res_credits++;
      if (!issued_any && (res_valid_i || op_credit_i)) begin
        errors++;
        $display("Output went active after reset before any operation was issued");
      end
      // Compare before pushing so a new issue never pairs with a stray result
      if (res_valid_i) begin
        results++;
        if (exp_data_q.size() == 0) begin
          errors++;
          $display("Result with tag %h arrived with no operation outstanding", res_tag_i);
        end else begin
          exp_data = exp_data_q.pop_front();
          exp_tag  = exp_tag_q.pop_front();
          if (res_data_i !== exp_data) begin
            errors++;
            $display("** Error: res_data_o got %h, expected %h (tag %h)",
                     res_data_i, exp_data, exp_tag);
          end
          if (res_tag_i !== exp_tag) begin
            errors++;
            $display("** Error: res_tag_o got %h, expected %h", res_tag_i, exp_tag);
          end
        end
      end
      if (op_valid_i) begin
        issued_any = 1'b1;
        exp_data_q.push_back(model_result(op_code_i, op_a_i, op_b_i));
        exp_tag_q.push_back(op_tag_i);
      end
      if (results > `DIV_RES_CREDITS + res_credits) begin
        errors++;
        $display("More results emitted (%0d) than downstream credits allow (%0d)",
                 results, `DIV_RES_CREDITS + res_credits);
      end
      if (totals_i) begin
        if (exp_data_q.size() != 0) begin
          errors++;
          $display("%0d issued operations never produced a result", exp_data_q.size());
        end
        if (op_credits != results) begin
          errors++;
          $display("** Error: op_credit_o pulse count got %h, expected %h", op_credits, results);
        end
        totals_done++;
      end
    end
    error_count_o  <= errors;
    result_count_o <= results;
    totals_done_o  <= totals_done;
  end

endmodule

`default_nettype wire

//--- tb_div_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "div_defines.svh"

module tb_div_unit;

  localparam int TIMEOUT   = 2000;
  localparam int MODE_MIX  = 0;
  localparam int MODE_ZERO = 1;
  localparam int MODE_OVF  = 2;
  localparam int MODE_B2B  = 3;

  logic               clk = 1'b0;
  logic               rst;
  logic               op_valid;
  div_pkg::div_op_e   op_code;
  div_pkg::div_word_t op_a;
  div_pkg::div_word_t op_b;
  div_pkg::div_tag_t  op_tag;
  logic               res_credit;
  logic               totals;
  logic               op_credit;
  logic               res_valid;
  div_pkg::div_word_t res_data;
  div_pkg::div_tag_t  res_tag;
  int                 error_count;
  int                 result_count;
  int                 totals_done;

  int unsigned lcg_state;
  int          issue_credits;
  // Results taken from the DUT but not yet credited back
  int          owed;
  int          ops_left;
  int          issued;
  int          mode;
  bit          return_on;
  bit          return_all;
  bit          totals_req;
  int          tests_run;
  int          tests_failed;

  always #5 clk = ~clk;

  div_unit u_dut (
    .clk          (clk),
    .rst          (rst),
    .op_valid_i   (op_valid),
    .op_code_i    (op_code),
    .op_a_i       (op_a),
    .op_b_i       (op_b),
    .op_tag_i     (op_tag),
    .op_credit_o  (op_credit),
    .res_valid_o  (res_valid),
    .res_data_o   (res_data),
    .res_tag_o    (res_tag),
    .res_credit_i (res_credit)
  );

  tb_div_checker u_chk (
    .clk            (clk),
    .rst            (rst),
    .op_valid_i     (op_valid),
    .op_code_i      (op_code),
    .op_a_i         (op_a),
    .op_b_i         (op_b),
    .op_tag_i       (op_tag),
    .op_credit_i    (op_credit),
    .res_valid_i    (res_valid),
    .res_data_i     (res_data),
    .res_tag_i      (res_tag),
    .res_credit_i   (res_credit),
    .totals_i       (totals),
    .error_count_o  (error_count),
    .result_count_o (result_count),
    .totals_done_o  (totals_done)
  );

  // Upper half of the state, the low bits cycle too fast
  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  function automatic div_pkg::div_word_t rand_word();
    int unsigned hi;
    int unsigned lo;
    hi = lcg_next();
    lo = lcg_next();
    return {hi[15:0], lo[15:0]};
  endfunction

  task automatic pick_op();
    div_pkg::div_word_t a;
    div_pkg::div_word_t b;
    div_pkg::div_op_e   code;
    int unsigned        sel;
    a    = rand_word();
    b    = rand_word();
    sel  = lcg_next() % 8;
    code = div_pkg::div_op_e'(3'd4 + 3'(lcg_next() % 4));
    if (mode == MODE_ZERO || (mode == MODE_MIX && sel == 0)) begin
      b = '0;
    end else if (mode == MODE_OVF || (mode == MODE_MIX && sel == 1)) begin
      a = {1'b1, {(`DIV_WORD_W-1){1'b0}}};
      b = '1;
      if (mode == MODE_OVF) code = sel[0] ? div_pkg::DIV_OP_DIV : div_pkg::DIV_OP_REM;
    end else if (sel == 2) begin
      a = a | {1'b1, {(`DIV_WORD_W-1){1'b0}}};
      b = ~(b & 32'hff);
    end else if (sel == 3) begin
      b = b & 32'hffff;
    end
    op_code <= code;
    op_a    <= a;
    op_b    <= b;
    op_tag  <= div_pkg::div_tag_t'(lcg_next());
  endtask

  // One clock of issuer and consumer activity, with credit bookkeeping
  task automatic cycle();
    bit issue;
    @(posedge clk);
    if (op_credit) issue_credits++;
    if (res_valid) owed++;
    issue = ops_left > 0 && issue_credits > 0 && (mode == MODE_B2B || lcg_next() % 4 != 0);
    if (issue) begin
      pick_op();
      issue_credits--;
      ops_left--;
      issued++;
    end
    op_valid <= issue;
    if (return_on && owed > 0 && (return_all || lcg_next() % 2 == 0)) begin
      res_credit <= 1'b1;
      owed--;
    end else begin
      res_credit <= 1'b0;
    end
    totals     <= totals_req;
    totals_req = 1'b0;
  endtask

  task automatic abort_run(input string what);
    $display("Timeout after %0d cycles waiting for %s", TIMEOUT, what);
    $display("Summary: %0d tests run, %0d failed, %0d results checked, %0d errors",
             tests_run, tests_failed, result_count, error_count);
    $display("Test failed");
    $finish;
  endtask

  task automatic issue_all(input int n);
    int waited;
    waited   = 0;
    ops_left = n;
    while (ops_left > 0) begin
      cycle();
      waited++;
      if (waited > TIMEOUT) abort_run("operations to issue");
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (result_count < issued || owed > 0) begin
      cycle();
      waited++;
      if (waited > TIMEOUT) abort_run("results to drain");
    end
  endtask

  task automatic close_test(input string name, input int err_start);
    int waited;
    int target;
    waited     = 0;
    target     = totals_done + 1;
    totals_req = 1'b1;
    while (totals_done < target) begin
      cycle();
      waited++;
      if (waited > TIMEOUT) abort_run("end of test checks");
    end
    tests_run++;
    if (error_count == err_start) begin
      $display("PASS %s", name);
    end else begin
      tests_failed++;
      $display("FAIL %s: %0d errors", name, error_count - err_start);
    end
  endtask

  task automatic run_test(input string name, input int m, input int n, input bit all);
    int err_start;
    err_start  = error_count;
    mode       = m;
    return_on  = 1'b1;
    return_all = all;
    issue_all(n);
    drain();
    close_test(name, err_start);
  endtask

  task automatic run_withheld();
    int err_start;
    err_start = error_count;
    mode      = MODE_MIX;
    return_on = 1'b0;
    issue_all(`DIV_FIFO_DEPTH + `DIV_RES_CREDITS);
    // Observation window with the consumer holding all credits
    repeat (4 * `DIV_STAGES) cycle();
    return_on = 1'b1;
    drain();
    close_test("withheld downstream credit", err_start);
  endtask

  initial begin
    rst           = 1'b1;
    op_valid      = 1'b0;
    op_code       = div_pkg::DIV_OP_DIV;
    op_a          = '0;
    op_b          = '0;
    op_tag        = '0;
    res_credit    = 1'b0;
    totals        = 1'b0;
    lcg_state     = 3851;
    issue_credits = 0;
    owed          = 0;
    ops_left      = 0;
    issued        = 0;
    mode          = MODE_MIX;
    return_on     = 1'b1;
    return_all    = 1'b0;
    totals_req    = 1'b0;
    tests_run     = 0;
    tests_failed  = 0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    issue_credits = `DIV_FIFO_DEPTH;
    repeat (12) cycle();
    close_test("outputs idle after reset", 0);
    run_test("random DIV/DIVU/REM/REMU", MODE_MIX, 300, 1'b0);
    run_test("zero divisor", MODE_ZERO, 32, 1'b0);
    run_test("signed overflow", MODE_OVF, 16, 1'b0);
    run_test("back-to-back issue", MODE_B2B, 64, 1'b1);
    run_withheld();
    $display("Summary: %0d tests run, %0d failed, %0d results checked, %0d errors",
             tests_run, tests_failed, result_count, error_count);
    if (tests_failed == 0 && error_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+.
div_pkg.sv
div_operand_prep.sv
div_stage.sv
div_result_fixup.sv
div_result_fifo.sv
div_unit.sv
tb_div_checker.sv
tb_div_unit.sv

//--- run.sh
#!/bin/sh
# Build and run the divider testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_div_unit \
  -o tb_div_unit > build.log 2>&1 \
  && ./obj_dir/tb_div_unit > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
